//--- logic/vdma_pkg.sv
package vdma_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    parameter int addr_w   = 32;
    parameter int data_w   = 32;
    parameter int len_w    = 8;
    parameter int stride_w = 14;
    parameter int h_w      = 10;
    parameter int v_w      = 10;
    parameter int index_w  = 8;

    parameter logic [31:0] core_id = 32'h527a_0011;

    // word offsets on the register bus
    typedef enum logic [7:0] {
        adr_core_id      = 8'h00,
        adr_ctl_control  = 8'h04,
        adr_ctl_status   = 8'h05,
        adr_ctl_index    = 8'h06,
        adr_param_addr   = 8'h08,
        adr_param_stride = 8'h09,
        adr_param_width  = 8'h0a,
        adr_param_height = 8'h0b,
        adr_param_arlen  = 8'h0f
    } reg_addr_e;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_line,
        st_wait_end,
        st_done
    } ctl_state_e;

    typedef struct packed {
        logic [addr_w-1:0]   addr;
        logic [stride_w-1:0] stride;
        logic [h_w-1:0]      width;
        logic [v_w-1:0]      height;
        logic [len_w-1:0]    arlen;
    } frame_param_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [h_w-1:0]    count;
    } line_req_t;

    // enable sits in bit 0
    typedef struct packed {
        logic oneshot;
        logic update;
        logic enable;
    } ctl_bits_t;

endpackage

//--- logic/vdma_regs.sv
module vdma_regs #(
    parameter int data_w = 32,
    parameter int addr_w = 32
) (
    input  logic                           s_wb_clk_i,
    input  logic                           s_wb_rst_i,
    input  logic [7:0]                     s_wb_adr_i,
    input  logic [data_w-1:0]              s_wb_dat_i,
    input  logic                           s_wb_we_i,
    input  logic [data_w/8-1:0]            s_wb_sel_i,
    input  logic                           s_wb_stb_i,
    output logic [data_w-1:0]              s_wb_dat_o,
    output logic                           s_wb_ack_o,
    input  logic                           busy_i,
    input  logic [vdma_pkg::index_w-1:0]   index_i,
    input  logic                           frame_end_i,
    output vdma_pkg::ctl_bits_t            ctl_o,
    output vdma_pkg::frame_param_t         param_o,
    output logic                           irq_o
);
    // low address bits below one data word
    localparam logic [addr_w-1:0] addr_mask = ~addr_w'(data_w / 8 - 1);

    vdma_pkg::ctl_bits_t    ctl_q;
    vdma_pkg::frame_param_t param_q;
    logic                   irq_q;
    logic [data_w-1:0]      wr_word;

    function automatic logic [data_w-1:0] byte_merge(
        input logic [data_w-1:0]   cur,
        input logic [data_w-1:0]   wdat,
        input logic [data_w/8-1:0] sel
    );
        logic [data_w-1:0] res;
        res = cur;
        for (int b = 0; b < data_w / 8; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = wdat[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // read side
    // ----------------------------------------------------------
    always_comb begin
        case (s_wb_adr_i)
            vdma_pkg::adr_core_id:      s_wb_dat_o = data_w'(vdma_pkg::core_id);
            vdma_pkg::adr_ctl_control:  s_wb_dat_o = data_w'(ctl_q);
            vdma_pkg::adr_ctl_status:   s_wb_dat_o = data_w'(busy_i);
            vdma_pkg::adr_ctl_index:    s_wb_dat_o = data_w'(index_i);
            vdma_pkg::adr_param_addr:   s_wb_dat_o = data_w'(param_q.addr);
            vdma_pkg::adr_param_stride: s_wb_dat_o = data_w'(param_q.stride);
            vdma_pkg::adr_param_width:  s_wb_dat_o = data_w'(param_q.width);
            vdma_pkg::adr_param_height: s_wb_dat_o = data_w'(param_q.height);
            vdma_pkg::adr_param_arlen:  s_wb_dat_o = data_w'(param_q.arlen);
            default:                    s_wb_dat_o = '0;
        endcase
    end

    // unselected bytes keep the addressed register's value
    assign wr_word    = byte_merge(s_wb_dat_o, s_wb_dat_i, s_wb_sel_i);
    assign s_wb_ack_o = s_wb_stb_i;

    // ----------------------------------------------------------
    // write side and frame end handling
    // ----------------------------------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            ctl_q          <= '0;
            param_q.addr   <= '0;
            param_q.stride <= vdma_pkg::stride_w'(4096);
            param_q.width  <= vdma_pkg::h_w'(640);
            param_q.height <= vdma_pkg::v_w'(480);
            param_q.arlen  <= vdma_pkg::len_w'(15);
            irq_q          <= 1'b0;
        end else begin
            irq_q <= frame_end_i;
            if (s_wb_stb_i && s_wb_we_i) begin
                case (s_wb_adr_i)
                    vdma_pkg::adr_ctl_control:
                        ctl_q <= wr_word[$bits(vdma_pkg::ctl_bits_t)-1:0];
                    vdma_pkg::adr_param_addr:
                        param_q.addr <= wr_word[addr_w-1:0] & addr_mask;
                    vdma_pkg::adr_param_stride:
                        param_q.stride <= wr_word[vdma_pkg::stride_w-1:0]
                                          & addr_mask[vdma_pkg::stride_w-1:0];
                    vdma_pkg::adr_param_width:
                        param_q.width <= wr_word[vdma_pkg::h_w-1:0];
                    vdma_pkg::adr_param_height:
                        param_q.height <= wr_word[vdma_pkg::v_w-1:0];
                    vdma_pkg::adr_param_arlen:
                        param_q.arlen <= wr_word[vdma_pkg::len_w-1:0];
                    default: ;
                endcase
            end
            if (frame_end_i) begin
                ctl_q.update <= 1'b0;
                // one-shot run stops itself
                if (ctl_q.oneshot) begin
                    ctl_q.enable  <= 1'b0;
                    ctl_q.oneshot <= 1'b0;
                end
            end
        end
    end

    assign ctl_o   = ctl_q;
    assign param_o = param_q;
    assign irq_o   = irq_q;

    // frame_end from the controller is a single-cycle pulse
    a_irq_single : assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        irq_q |=> !irq_q);

endmodule

//--- logic/vdma_ctrl.sv
module vdma_ctrl #(
    parameter int index_w = 8
) (
    input  logic                                   s_wb_clk_i,
    input  logic                                   s_wb_rst_i,
    input  vdma_pkg::ctl_bits_t                    ctl_i,
    input  vdma_pkg::frame_param_t                 param_i,
    output logic                                   busy_o,
    output logic [index_w-1:0]                     index_o,
    output logic                                   frame_end_o,
    output logic                                   line_req_o,
    output vdma_pkg::line_req_t                    line_o,
    input  logic                                   line_ack_i,
    output logic                                   frame_req_o,
    output logic [vdma_pkg::v_w+vdma_pkg::h_w-1:0] geom_o,
    input  logic                                   frame_ack_i
);
    vdma_pkg::ctl_state_e          state_q;
    vdma_pkg::frame_param_t        shadow_q;
    vdma_pkg::frame_param_t        next_shadow;
    vdma_pkg::line_req_t           line_q;
    logic [vdma_pkg::v_w-1:0]      y_q;
    logic [index_w-1:0]            index_q;
    logic [vdma_pkg::addr_w-1:0]   stride_ext;
    logic                          reload_q;
    logic                          line_req_q;
    logic                          frame_req_q;
    logic                          frame_end_q;
    logic                          line_done;

    // first frame after enable, or update seen at the last frame end
    assign next_shadow = (reload_q || ctl_i.update) ? param_i : shadow_q;
    assign stride_ext  = {{(vdma_pkg::addr_w - vdma_pkg::stride_w){1'b0}}, shadow_q.stride};
    assign line_done   = line_req_q && line_ack_i;

    // ----------------------------------------------------------
    // frame FSM
    // ----------------------------------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            state_q     <= vdma_pkg::st_idle;
            y_q         <= '0;
            index_q     <= '0;
            reload_q    <= 1'b1;
            line_req_q  <= 1'b0;
            frame_req_q <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            frame_end_q <= 1'b0;
            case (state_q)
                vdma_pkg::st_idle: begin
                    reload_q <= 1'b1;
                    if (ctl_i.enable) begin
                        state_q <= vdma_pkg::st_start;
                    end
                end
                vdma_pkg::st_start: begin
                    y_q         <= '0;
                    frame_req_q <= 1'b1;
                    state_q     <= vdma_pkg::st_line;
                end
                vdma_pkg::st_line: begin
                    // next request only once the previous ack is gone
                    if (!line_req_q && !line_ack_i) begin
                        line_req_q <= 1'b1;
                    end else if (line_done) begin
                        line_req_q <= 1'b0;
                        y_q        <= y_q + 1'b1;
                        if (y_q == shadow_q.height - 1'b1) begin
                            state_q <= vdma_pkg::st_wait_end;
                        end
                    end
                end
                vdma_pkg::st_wait_end: begin
                    if (frame_ack_i) begin
                        frame_req_q <= 1'b0;
                        index_q     <= index_q + 1'b1;
                        frame_end_q <= 1'b1;
                        reload_q    <= ctl_i.update;
                        state_q     <= vdma_pkg::st_done;
                    end
                end
                vdma_pkg::st_done: begin
                    if (!frame_ack_i) begin
                        state_q <= ctl_i.enable ? vdma_pkg::st_start : vdma_pkg::st_idle;
                    end
                end
                default: state_q <= vdma_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (state_q == vdma_pkg::st_start) begin
            shadow_q     <= next_shadow;
            line_q.addr  <= next_shadow.addr;
            line_q.count <= next_shadow.width;
        end else if (state_q == vdma_pkg::st_line && line_done) begin
            line_q.addr <= line_q.addr + stride_ext;
        end
    end

    assign busy_o      = state_q != vdma_pkg::st_idle;
    assign index_o     = index_q;
    assign frame_end_o = frame_end_q;
    assign line_req_o  = line_req_q;
    assign line_o      = line_q;
    assign frame_req_o = frame_req_q;
    assign geom_o      = {shadow_q.height, shadow_q.width};

    a_req_hold : assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        $fell(line_req_q) |-> $past(line_ack_i));

endmodule

//--- logic/vdma_ar_issue.sv
module vdma_ar_issue #(
    parameter int addr_w = 32,
    parameter int len_w  = 8
) (
    input  logic                s_wb_clk_i,
    input  logic                s_wb_rst_i,
    input  logic                line_req_i,
    input  vdma_pkg::line_req_t line_i,
    input  logic [len_w-1:0]    arlen_i,
    output logic                line_ack_o,
    output logic [addr_w-1:0]   m_axi4_araddr_o,
    output logic [len_w-1:0]    m_axi4_arlen_o,
    output logic                m_axi4_arvalid_o,
    input  logic                m_axi4_arready_i
);
    localparam int cnt_w = (vdma_pkg::h_w > len_w + 1) ? vdma_pkg::h_w : len_w + 1;

    logic              active_q;
    logic              ack_q;
    logic              arvalid_q;
    logic [cnt_w-1:0]  remain_q;
    logic [cnt_w-1:0]  burst_max;
    logic [cnt_w-1:0]  beats;
    logic [addr_w-1:0] next_addr_q;
    logic [addr_w-1:0] araddr_q;
    logic [len_w-1:0]  arlen_q;
    logic              ar_fire;
    logic              issue;

    assign ar_fire   = arvalid_q && m_axi4_arready_i;
    assign burst_max = cnt_w'(arlen_i) + 1'b1;
    // short tail burst keeps the line boundary
    assign beats     = (remain_q > burst_max) ? burst_max : remain_q;
    assign issue     = active_q && remain_q != '0 && (!arvalid_q || m_axi4_arready_i);

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            active_q  <= 1'b0;
            ack_q     <= 1'b0;
            arvalid_q <= 1'b0;
            remain_q  <= '0;
        end else begin
            if (!active_q && !ack_q && line_req_i) begin
                active_q <= 1'b1;
                remain_q <= cnt_w'(line_i.count);
            end else if (issue) begin
                remain_q <= remain_q - beats;
            end
            if (issue) begin
                arvalid_q <= 1'b1;
            end else if (ar_fire) begin
                arvalid_q <= 1'b0;
            end
            // ack after the last burst of the line is accepted
            if (active_q && remain_q == '0 && ar_fire) begin
                active_q <= 1'b0;
                ack_q    <= 1'b1;
            end else if (!line_req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (!active_q && line_req_i) begin
            next_addr_q <= line_i.addr;
        end else if (issue) begin
            araddr_q    <= next_addr_q;
            arlen_q     <= len_w'(beats - 1'b1);
            next_addr_q <= next_addr_q + addr_w'({beats, 2'b00});
        end
    end

    assign line_ack_o       = ack_q;
    assign m_axi4_araddr_o  = araddr_q;
    assign m_axi4_arlen_o   = arlen_q;
    assign m_axi4_arvalid_o = arvalid_q;

    a_ar_stable : assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        arvalid_q && !m_axi4_arready_i |=> arvalid_q && $stable(araddr_q));

endmodule

//--- logic/vdma_r_stream.sv
module vdma_r_stream #(
    parameter int data_w = 32,
    parameter int h_w    = 10,
    parameter int v_w    = 10
) (
    input  logic               s_wb_clk_i,
    input  logic               s_wb_rst_i,
    input  logic               frame_req_i,
    input  logic [v_w+h_w-1:0] geom_i,
    output logic               frame_ack_o,
    input  logic [data_w-1:0]  m_axi4_rdata_i,
    input  logic               m_axi4_rvalid_i,
    output logic               m_axi4_rready_o,
    output logic [data_w-1:0]  m_axi4s_tdata_o,
    output logic               m_axi4s_tuser_o,
    output logic               m_axi4s_tlast_o,
    output logic               m_axi4s_tvalid_o,
    input  logic               m_axi4s_tready_i
);
    logic [h_w-1:0]    width;
    logic [v_w-1:0]    height;
    logic [h_w-1:0]    x_q;
    logic [v_w-1:0]    y_q;
    logic [data_w-1:0] tdata_q;
    logic              tvalid_q;
    logic              tuser_q;
    logic              tlast_q;
    logic              fend_q;
    logic              ack_q;
    logic              rd_fire;
    logic              x_last;
    logic              y_last;

    assign {height, width}  = geom_i;
    assign m_axi4_rready_o  = !tvalid_q || m_axi4s_tready_i;
    assign rd_fire          = m_axi4_rvalid_i && m_axi4_rready_o;
    assign x_last           = x_q == width - 1'b1;
    assign y_last           = y_q == height - 1'b1;

    // ----------------------------------------------------------
    // output register and pixel position
    // ----------------------------------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            tvalid_q <= 1'b0;
            x_q      <= '0;
            y_q      <= '0;
            ack_q    <= 1'b0;
        end else begin
            if (rd_fire) begin
                tvalid_q <= 1'b1;
            end else if (m_axi4s_tready_i) begin
                tvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                if (x_last) begin
                    x_q <= '0;
                    y_q <= y_last ? '0 : y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
            // frame done once its last pixel leaves
            if (tvalid_q && m_axi4s_tready_i && fend_q) begin
                ack_q <= 1'b1;
            end else if (!frame_req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (rd_fire) begin
            tdata_q <= m_axi4_rdata_i;
            tuser_q <= x_q == '0 && y_q == '0;
            tlast_q <= x_last;
            fend_q  <= x_last && y_last;
        end
    end

    assign frame_ack_o      = ack_q;
    assign m_axi4s_tdata_o  = tdata_q;
    assign m_axi4s_tuser_o  = tuser_q;
    assign m_axi4s_tlast_o  = tlast_q;
    assign m_axi4s_tvalid_o = tvalid_q;

    a_tvalid_hold : assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        tvalid_q && !m_axi4s_tready_i |=> tvalid_q && $stable(tdata_q));

endmodule

//--- logic/vdma_top.sv
module vdma_top #(
    parameter int addr_w  = vdma_pkg::addr_w,
    parameter int data_w  = vdma_pkg::data_w,
    parameter int len_w   = vdma_pkg::len_w,
    parameter int index_w = vdma_pkg::index_w,
    parameter int h_w     = vdma_pkg::h_w,
    parameter int v_w     = vdma_pkg::v_w
) (
    input  logic                s_wb_clk_i,
    input  logic                s_wb_rst_i,
    input  logic [7:0]          s_wb_adr_i,
    input  logic [data_w-1:0]   s_wb_dat_i,
    input  logic                s_wb_we_i,
    input  logic [data_w/8-1:0] s_wb_sel_i,
    input  logic                s_wb_stb_i,
    output logic [data_w-1:0]   s_wb_dat_o,
    output logic                s_wb_ack_o,
    output logic                irq_o,
    output logic [addr_w-1:0]   m_axi4_araddr_o,
    output logic [len_w-1:0]    m_axi4_arlen_o,
    output logic [2:0]          m_axi4_arsize_o,
    output logic [1:0]          m_axi4_arburst_o,
    output logic                m_axi4_arvalid_o,
    input  logic                m_axi4_arready_i,
    input  logic [data_w-1:0]   m_axi4_rdata_i,
    input  logic                m_axi4_rvalid_i,
    output logic                m_axi4_rready_o,
    output logic [data_w-1:0]   m_axi4s_tdata_o,
    output logic                m_axi4s_tuser_o,
    output logic                m_axi4s_tlast_o,
    output logic                m_axi4s_tvalid_o,
    input  logic                m_axi4s_tready_i
);
    vdma_pkg::ctl_bits_t    ctl;
    vdma_pkg::frame_param_t param;
    vdma_pkg::line_req_t    line;
    logic                   busy;
    logic [index_w-1:0]     index;
    logic                   frame_end;
    logic                   line_req;
    logic                   line_ack;
    logic                   frame_req;
    logic                   frame_ack;
    logic [v_w+h_w-1:0]     geom;

    // one beat per word, incrementing bursts
    assign m_axi4_arsize_o  = 3'($clog2(data_w / 8));
    assign m_axi4_arburst_o = 2'b01;

    vdma_regs #(.data_w(data_w), .addr_w(addr_w)) u_regs (
        .s_wb_clk_i, .s_wb_rst_i, .s_wb_adr_i, .s_wb_dat_i, .s_wb_we_i,
        .s_wb_sel_i, .s_wb_stb_i, .s_wb_dat_o, .s_wb_ack_o,
        .busy_i(busy), .index_i(index), .frame_end_i(frame_end),
        .ctl_o(ctl), .param_o(param), .irq_o
    );

    vdma_ctrl #(.index_w(index_w)) u_ctrl (
        .s_wb_clk_i, .s_wb_rst_i, .ctl_i(ctl), .param_i(param),
        .busy_o(busy), .index_o(index), .frame_end_o(frame_end),
        .line_req_o(line_req), .line_o(line), .line_ack_i(line_ack),
        .frame_req_o(frame_req), .geom_o(geom), .frame_ack_i(frame_ack)
    );

    vdma_ar_issue #(.addr_w(addr_w), .len_w(len_w)) u_ar_issue (
        .s_wb_clk_i, .s_wb_rst_i, .line_req_i(line_req), .line_i(line),
        .arlen_i(param.arlen), .line_ack_o(line_ack),
        .m_axi4_araddr_o, .m_axi4_arlen_o, .m_axi4_arvalid_o, .m_axi4_arready_i
    );

    vdma_r_stream #(.data_w(data_w), .h_w(h_w), .v_w(v_w)) u_r_stream (
        .s_wb_clk_i, .s_wb_rst_i, .frame_req_i(frame_req), .geom_i(geom),
        .frame_ack_o(frame_ack), .m_axi4_rdata_i, .m_axi4_rvalid_i, .m_axi4_rready_o,
        .m_axi4s_tdata_o, .m_axi4s_tuser_o, .m_axi4s_tlast_o, .m_axi4s_tvalid_o,
        .m_axi4s_tready_i
    );

endmodule

//--- dv/axi_mem_model.sv
module axi_mem_model #(
    parameter int          addr_w   = 32,
    parameter int          data_w   = 32,
    parameter int          len_w    = 8,
    parameter logic [31:0] data_key = 32'h0
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [addr_w-1:0] araddr_i,
    input  logic [len_w-1:0]  arlen_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [data_w-1:0] rdata_o,
    output logic              rvalid_o,
    input  logic              rready_i
);
    integer            seed = 32'he1e;
    logic [addr_w-1:0] beat_q[$];
    logic              arready_q = 1'b0;
    logic [data_w-1:0] rdata_q = '0;
    logic              rvalid_q = 1'b0;

    always @(posedge clk_i) begin
        if (rst_i) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            beat_q.delete();
        end else begin
            // one entry per beat, word addresses counting up
            if (arvalid_i && arready_q) begin
                for (int i = 0; i <= int'(arlen_i); i++) begin
                    beat_q.push_back(araddr_i + addr_w'(4 * i));
                end
            end
            arready_q <= ($random(seed) & 3) != 0;
            // next beat once the current one is taken, with random gaps
            if (!rvalid_q || rready_i) begin
                if (beat_q.size() != 0 && ($random(seed) & 3) != 0) begin
                    rdata_q  <= data_w'(beat_q.pop_front() ^ addr_w'(data_key));
                    rvalid_q <= 1'b1;
                end else begin
                    rvalid_q <= 1'b0;
                end
            end
        end
    end

    assign arready_o = arready_q;
    assign rdata_o   = rdata_q;
    assign rvalid_o  = rvalid_q;

endmodule

//--- dv/tb_vdma.sv
module tb_vdma;
    localparam int          width_px  = 5;
    localparam int          height_a  = 3;
    localparam int          height_b  = 2;
    localparam int          burst_len = 1;
    localparam int          base_addr = 32'h0000_1000;
    localparam int          stride_b  = 64;
    localparam logic [31:0] data_key  = 32'h5a3c_96e1;
    localparam int          n_frames  = 7;
    // per frame: every beat stalled on three channels, plus line handshakes
    localparam int max_cycles = 600 + n_frames * (width_px * height_a * 16 + height_a * 40);

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_ack;
    logic        irq;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [31:0] tdata;
    logic        tuser;
    logic        tlast;
    logic        tvalid;
    logic        tready = 1'b0;

    integer      seed = 32'he1e;
    logic        bp_on = 1'b0;
    logic        stream_on;
    logic        chk_rd;
    logic [31:0] exp_rd;
    logic        beat;
    logic        ar_fire;
    int          cur_h;
    int          n_done;
    int          x_exp;
    int          y_exp;
    int          ar_off;
    int          ar_line;
    int          frames_done;
    int          irq_cnt;
    int          cycles;

    always #5 clk = ~clk;

    vdma_top DUT (
        .s_wb_clk_i(clk), .s_wb_rst_i(rst), .s_wb_adr_i(wb_adr), .s_wb_dat_i(wb_dat_w),
        .s_wb_we_i(wb_we), .s_wb_sel_i(wb_sel), .s_wb_stb_i(wb_stb),
        .s_wb_dat_o(wb_dat_r), .s_wb_ack_o(wb_ack), .irq_o(irq),
        .m_axi4_araddr_o(araddr), .m_axi4_arlen_o(arlen), .m_axi4_arsize_o(arsize),
        .m_axi4_arburst_o(arburst), .m_axi4_arvalid_o(arvalid), .m_axi4_arready_i(arready),
        .m_axi4_rdata_i(rdata), .m_axi4_rvalid_i(rvalid), .m_axi4_rready_o(rready),
        .m_axi4s_tdata_o(tdata), .m_axi4s_tuser_o(tuser), .m_axi4s_tlast_o(tlast),
        .m_axi4s_tvalid_o(tvalid), .m_axi4s_tready_i(tready)
    );

    axi_mem_model #(.data_key(data_key)) u_mem (
        .clk_i(clk), .rst_i(rst), .araddr_i(araddr), .arlen_i(arlen),
        .arvalid_i(arvalid), .arready_o(arready), .rdata_o(rdata),
        .rvalid_o(rvalid), .rready_i(rready)
    );

    assign beat    = tvalid && tready;
    assign ar_fire = arvalid && arready;

    function automatic logic [31:0] pixel_word(input int x, input int y);
        return (base_addr + y * stride_b + 4 * x) ^ data_key;
    endfunction

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        @(posedge clk);
        wb_adr   <= adr;
        wb_dat_w <= dat;
        wb_sel   <= sel;
        wb_we    <= 1'b1;
        wb_stb   <= 1'b1;
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_read(input logic [7:0] adr, input logic [31:0] want);
        @(posedge clk);
        wb_adr <= adr;
        wb_we  <= 1'b0;
        wb_stb <= 1'b1;
        exp_rd <= want;
        chk_rd <= 1'b1;
        @(posedge clk);
        wb_stb <= 1'b0;
        chk_rd <= 1'b0;
    endtask

    task automatic wait_frame();
        do @(posedge clk); while (!irq);
        n_done++;
    endtask

    // ----------------------------------------------------------
    // stream and burst position tracking
    // ----------------------------------------------------------
    always @(posedge clk) begin
        tready <= !bp_on || (($random(seed) & 3) != 0);
    end

    always @(posedge clk) begin
        if (rst) begin
            x_exp       <= 0;
            y_exp       <= 0;
            ar_off      <= 0;
            ar_line     <= 0;
            frames_done <= 0;
            irq_cnt     <= 0;
        end else begin
            if (beat) begin
                if (x_exp == width_px - 1) begin
                    x_exp <= 0;
                    if (y_exp == cur_h - 1) begin
                        y_exp       <= 0;
                        frames_done <= frames_done + 1;
                    end else begin
                        y_exp <= y_exp + 1;
                    end
                end else begin
                    x_exp <= x_exp + 1;
                end
            end
            if (ar_fire) begin
                if (ar_off + int'(arlen) + 1 >= width_px) begin
                    ar_off  <= 0;
                    ar_line <= (ar_line == cur_h - 1) ? 0 : ar_line + 1;
                end else begin
                    ar_off <= ar_off + int'(arlen) + 1;
                end
            end
            if (irq) begin
                irq_cnt <= irq_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= rst ? 0 : cycles + 1;
        if (cycles == max_cycles) begin
            stop_fail($sformatf("run did not finish within %0d cycles", max_cycles));
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    a_read : assert property (@(posedge clk) disable iff (rst) chk_rd |-> wb_dat_r == exp_rd)
        else stop_fail($sformatf("ERROR %0t: register %h read %h, expected %h",
                                 $time, wb_adr, wb_dat_r, exp_rd));
    a_ack : assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_ack)
        else stop_fail($sformatf("%0t: Wishbone access got no ack", $time));
    a_pixel : assert property (@(posedge clk) disable iff (rst)
        beat |-> tdata == pixel_word(x_exp, y_exp))
        else stop_fail($sformatf("ERROR %0t: pixel x=%0d y=%0d data %h, expected %h",
                                 $time, x_exp, y_exp, tdata, pixel_word(x_exp, y_exp)));
    a_user : assert property (@(posedge clk) disable iff (rst)
        beat |-> tuser == (x_exp == 0 && y_exp == 0))
        else stop_fail($sformatf("ERROR %0t: tuser %b at x=%0d y=%0d",
                                 $time, tuser, x_exp, y_exp));
    a_last : assert property (@(posedge clk) disable iff (rst)
        beat |-> tlast == (x_exp == width_px - 1))
        else stop_fail($sformatf("ERROR %0t: tlast %b at x=%0d", $time, tlast, x_exp));
    a_hold : assert property (@(posedge clk) disable iff (rst)
        tvalid && !tready |=> tvalid && $stable({tdata, tuser, tlast}))
        else stop_fail($sformatf("%0t: stream beat changed while stalled", $time));
    // a read beat may only be taken when the output register has room
    a_no_overrun : assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |-> !tvalid || tready)
        else stop_fail($sformatf("%0t: read beat taken while the stream was stalled", $time));
    a_idle : assert property (@(posedge clk) disable iff (rst)
        !stream_on |-> !tvalid && !arvalid)
        else stop_fail($sformatf("%0t: traffic while no frame was expected", $time));
    a_ar_fmt : assert property (@(posedge clk) disable iff (rst)
        arvalid |-> int'(arlen) <= burst_len && arsize == 3'd2 && arburst == 2'b01)
        else stop_fail($sformatf("ERROR %0t: burst arlen %0d size %0d type %0d",
                                 $time, arlen, arsize, arburst));
    a_ar_pos : assert property (@(posedge clk) disable iff (rst)
        ar_fire |-> int'(araddr) == base_addr + ar_line * stride_b + 4 * ar_off
                    && ar_off + int'(arlen) + 1 <= width_px)
        else stop_fail($sformatf("ERROR %0t: burst at %h len %0d, line %0d offset %0d",
                                 $time, araddr, arlen, ar_line, ar_off));
    a_irq_pulse : assert property (@(posedge clk) disable iff (rst) irq |=> !irq)
        else stop_fail($sformatf("%0t: interrupt stayed high for two cycles", $time));
    a_irq_frame : assert property (@(posedge clk) disable iff (rst)
        irq |-> frames_done == irq_cnt + 1 && x_exp == 0 && y_exp == 0)
        else stop_fail($sformatf("ERROR %0t: interrupt %0d after %0d frames",
                                 $time, irq_cnt + 1, frames_done));

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin
        rst       = 1'b1;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_we     = 1'b0;
        wb_sel    = '0;
        wb_stb    = 1'b0;
        chk_rd    = 1'b0;
        exp_rd    = '0;
        stream_on = 1'b0;
        cur_h     = height_a;
        n_done    = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        check_read(vdma_pkg::adr_core_id, vdma_pkg::core_id);
        write_reg(vdma_pkg::adr_param_addr, 32'h1000_0003, 4'hf);
        check_read(vdma_pkg::adr_param_addr, 32'h1000_0000);
        write_reg(vdma_pkg::adr_param_addr, 32'h00ab_0000, 4'b0100);
        check_read(vdma_pkg::adr_param_addr, 32'h10ab_0000);
        write_reg(vdma_pkg::adr_param_stride, 32'h0000_0143, 4'hf);
        check_read(vdma_pkg::adr_param_stride, 32'h0000_0140);

        write_reg(vdma_pkg::adr_param_addr, base_addr, 4'hf);
        write_reg(vdma_pkg::adr_param_stride, stride_b, 4'hf);
        write_reg(vdma_pkg::adr_param_width, width_px, 4'hf);
        write_reg(vdma_pkg::adr_param_height, height_a, 4'hf);
        write_reg(vdma_pkg::adr_param_arlen, burst_len, 4'hf);
        check_read(vdma_pkg::adr_param_arlen, burst_len);

        // single frame, enable plus oneshot
        stream_on <= 1'b1;
        write_reg(vdma_pkg::adr_ctl_control, 32'h5, 4'hf);
        wait_frame();
        stream_on <= 1'b0;
        check_read(vdma_pkg::adr_ctl_control, 32'h0);
        check_read(vdma_pkg::adr_ctl_status, 32'h0);
        check_read(vdma_pkg::adr_ctl_index, 32'(n_done));
        repeat (20) @(posedge clk);

        // continuous run with stalls everywhere
        bp_on     <= 1'b1;
        stream_on <= 1'b1;
        write_reg(vdma_pkg::adr_ctl_control, 32'h1, 4'hf);
        wait_frame();
        write_reg(vdma_pkg::adr_param_height, height_b, 4'hf);
        check_read(vdma_pkg::adr_ctl_index, 32'(n_done));
        wait_frame();
        wait_frame();
        write_reg(vdma_pkg::adr_ctl_control, 32'h3, 4'hf);
        wait_frame();
        // new height from the next frame on
        cur_h <= height_b;
        check_read(vdma_pkg::adr_ctl_control, 32'h1);
        wait_frame();
        write_reg(vdma_pkg::adr_ctl_control, 32'h0, 4'hf);
        wait_frame();
        stream_on <= 1'b0;
        check_read(vdma_pkg::adr_ctl_status, 32'h0);
        check_read(vdma_pkg::adr_ctl_index, 32'(n_done));
        repeat (20) @(posedge clk);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- vdma_top.f
logic/vdma_pkg.sv
logic/vdma_regs.sv
logic/vdma_ctrl.sv
logic/vdma_ar_issue.sv
logic/vdma_r_stream.sv
logic/vdma_top.sv
dv/axi_mem_model.sv
dv/tb_vdma.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_vdma
FILELIST  := vdma_top.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
